//--- logic/io_links_pkg.sv
package io_links_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes and limits
	////////////////////////////////////////////////////////////////////////////

	localparam int nlinks = 4;
	localparam int words_per_link = 4;
	localparam int delay_max = 31;
	localparam int flush_cycles = 32;

	// Word indices within one lane
	localparam int reg_ctrl = 0;
	localparam int reg_status = 1;
	localparam int reg_errors = 2;
	// Shared word after the last lane
	localparam int reg_global = nlinks * words_per_link;

	typedef logic [7:0] byte_t;
	typedef logic [4:0] tap_t;
	typedef logic [2:0] slip_t;
	typedef logic [15:0] err_cnt_t;
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		byte_t tdata;
		logic tvalid;
	} link_in_t;

	typedef struct packed {
		byte_t tdata;
		logic tvalid;
	} link_out_t;

	// One line bit per cycle, en low means the line floats
	typedef struct packed {
		logic data;
		logic en;
	} line_sample_t;

	typedef struct packed {
		logic bypass;
		logic tristate;
		tap_t taps;
		slip_t slip;
	} link_ctrl_t;

	typedef struct packed {
		logic delay_ready;
		tap_t taps_out;
		err_cnt_t err_cnt;
	} link_stat_t;

	typedef enum logic {
		idle,
		shift
	} ser_state_t;

endpackage

//--- logic/link_config_regs.sv
`timescale 1ns/1ps

module link_config_regs (
	input logic in_clk160,
	input logic rst_n,
	input io_links_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input io_links_pkg::apb_data_t pwdata,
	output io_links_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output io_links_pkg::link_ctrl_t [io_links_pkg::nlinks-1:0] ctrl,
	input io_links_pkg::link_stat_t [io_links_pkg::nlinks-1:0] stat,
	output logic [io_links_pkg::nlinks-1:0] clear_cnt
);
	import io_links_pkg::*;

	int word_num;
	int lane_idx;
	int sub_idx;
	logic access;
	logic addr_ok;
	logic wr_en;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	// Byte address to word, then split into lane and word within lane
	assign word_num = int'(paddr[7:2]);
	assign lane_idx = word_num / words_per_link;
	assign sub_idx = word_num % words_per_link;

	// Reserved last word of each lane and anything past global
	assign addr_ok = (word_num == reg_global) ||
		((word_num < reg_global) && (sub_idx <= reg_errors));

	assign access = psel & penable;
	assign wr_en = access & pwrite & addr_ok;

	// No wait states
	assign pready = access;
	assign pslverr = access & ~addr_ok;

	////////////////////////////////////////////////////////////////////////////
	// Control words and counter clears
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
			clear_cnt <= '0;
		end else begin
			clear_cnt <= '0;
			if (wr_en) begin
				for (int l = 0; l < nlinks; l++) begin
					if (word_num == l * words_per_link + reg_ctrl) begin
						ctrl[l].bypass <= pwdata[0];
						ctrl[l].tristate <= pwdata[1];
						ctrl[l].taps <= pwdata[12:8];
						ctrl[l].slip <= pwdata[18:16];
						// Bit 2 is a strobe, never stored
						clear_cnt[l] <= pwdata[2];
					end
				end
				if (word_num == reg_global && pwdata[0]) begin
					clear_cnt <= '1;
				end
			end
		end
	end

	// Readback mux, global word falls through as zero
	always_comb begin
		prdata = '0;
		for (int l = 0; l < nlinks; l++) begin
			if (lane_idx == l && word_num < reg_global) begin
				case (sub_idx)
					reg_ctrl: begin
						prdata[0] = ctrl[l].bypass;
						prdata[1] = ctrl[l].tristate;
						prdata[12:8] = ctrl[l].taps;
						prdata[18:16] = ctrl[l].slip;
					end
					reg_status: begin
						prdata[0] = stat[l].delay_ready;
						prdata[12:8] = stat[l].taps_out;
					end
					reg_errors: begin
						prdata[15:0] = stat[l].err_cnt;
					end
					default: begin
						prdata = '0;
					end
				endcase
			end
		end
	end

endmodule

//--- logic/link_serializer.sv
`timescale 1ns/1ps

module link_serializer (
	input logic in_clk160,
	input logic rst_n,
	input io_links_pkg::link_in_t link_in,
	output logic in_tready,
	input logic tristate,
	output io_links_pkg::line_sample_t sample
);
	import io_links_pkg::*;

	ser_state_t state;
	ser_state_t state_d;
	logic [2:0] bit_cnt;
	logic [2:0] bit_cnt_d;
	byte_t shreg;
	logic take;

	assign take = link_in.tvalid & in_tready;

	// Next byte loads during the last shift cycle
	always_comb begin
		state_d = state;
		bit_cnt_d = bit_cnt;
		if (take) begin
			state_d = shift;
			bit_cnt_d = 3'd0;
		end else if (state == shift) begin
			bit_cnt_d = bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				state_d = idle;
			end
		end
	end

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			bit_cnt <= '0;
			in_tready <= 1'b0;
		end else begin
			state <= state_d;
			bit_cnt <= bit_cnt_d;
			in_tready <= (state_d == idle) || (bit_cnt_d == 3'd7);
		end
	end

	// MSB first
	always_ff @(posedge in_clk160) begin
		if (take) begin
			shreg <= link_in.tdata;
		end else if (state == shift) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	// Line driven only while shifting and not tristated
	assign sample.en = (state == shift) & ~tristate;
	assign sample.data = shreg[7] & sample.en;

endmodule

//--- logic/link_delay_line.sv
`timescale 1ns/1ps

module link_delay_line (
	input logic in_clk160,
	input logic rst_n,
	input io_links_pkg::tap_t taps,
	input io_links_pkg::line_sample_t sample_in,
	output io_links_pkg::line_sample_t sample_out,
	output logic delay_ready,
	output io_links_pkg::tap_t taps_out
);
	import io_links_pkg::*;

	line_sample_t [delay_max-1:0] sreg;
	line_sample_t [delay_max:0] tap_vec;
	logic [5:0] flush_cnt;

	// Tap 0 is the live input, so total delay is taps + 1
	assign tap_vec = {sreg, sample_in};

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			sreg <= '0;
			sample_out <= '0;
		end else begin
			sreg <= {sreg[delay_max-2:0], sample_in};
			sample_out <= tap_vec[taps_out];
		end
	end

	// Applied tap and settle time after each change
	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			taps_out <= '0;
			flush_cnt <= '0;
		end else begin
			taps_out <= taps;
			if (taps != taps_out) begin
				flush_cnt <= 6'(flush_cycles);
			end else if (flush_cnt != '0) begin
				flush_cnt <= flush_cnt - 6'd1;
			end
		end
	end

	assign delay_ready = (flush_cnt == '0);

endmodule

//--- logic/link_deserializer.sv
`timescale 1ns/1ps

module link_deserializer (
	input logic in_clk160,
	input logic rst_n,
	input io_links_pkg::line_sample_t sample,
	input io_links_pkg::slip_t slip,
	input logic bypass,
	input io_links_pkg::link_in_t link_in,
	input logic clear_cnt,
	output io_links_pkg::link_out_t link_out,
	output io_links_pkg::err_cnt_t err_cnt
);
	import io_links_pkg::*;

	byte_t win_data;
	byte_t win_en;
	byte_t win_data_d;
	byte_t win_en_d;
	logic prev_en;
	logic [2:0] bit_cnt;
	logic [2:0] phase;
	logic boundary;
	logic partial;
	link_out_t line_q;
	link_in_t byp_q1;
	link_in_t byp_q2;

	////////////////////////////////////////////////////////////////////////////
	// Word alignment
	////////////////////////////////////////////////////////////////////////////

	// Phase restarts on the first driven bit of a burst
	assign phase = (sample.en && !prev_en) ? 3'd0 : bit_cnt;
	assign boundary = (phase == slip - 3'd1);

	assign win_data_d = {win_data[6:0], sample.data};
	assign win_en_d = {win_en[6:0], sample.en};

	// Window that straddles a burst edge
	assign partial = (|win_en_d) & ~(&win_en_d);

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			win_en <= '0;
			prev_en <= 1'b0;
			bit_cnt <= '0;
			line_q.tvalid <= 1'b0;
		end else begin
			win_en <= win_en_d;
			prev_en <= sample.en;
			bit_cnt <= phase + 3'd1;
			line_q.tvalid <= boundary & (&win_en_d);
		end
	end

	always_ff @(posedge in_clk160) begin
		win_data <= win_data_d;
		if (boundary) begin
			line_q.tdata <= win_data_d;
		end
	end

	// Saturating error count, clear wins
	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			err_cnt <= '0;
		end else if (clear_cnt) begin
			err_cnt <= '0;
		end else if (boundary && partial && err_cnt != '1) begin
			err_cnt <= err_cnt + 16'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bypass path
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			byp_q1.tvalid <= 1'b0;
			byp_q2.tvalid <= 1'b0;
		end else begin
			byp_q1.tvalid <= link_in.tvalid;
			byp_q2.tvalid <= byp_q1.tvalid;
		end
	end

	always_ff @(posedge in_clk160) begin
		byp_q1.tdata <= link_in.tdata;
		byp_q2.tdata <= byp_q1.tdata;
	end

	assign link_out.tdata = bypass ? byp_q2.tdata : line_q.tdata;
	assign link_out.tvalid = bypass ? byp_q2.tvalid : line_q.tvalid;

endmodule

//--- logic/io_links.sv
`timescale 1ns/1ps

module io_links (
	input logic in_clk160,
	input logic rst_n,
	input io_links_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input io_links_pkg::apb_data_t pwdata,
	output io_links_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input io_links_pkg::link_in_t [io_links_pkg::nlinks-1:0] link_in,
	output logic [io_links_pkg::nlinks-1:0] in_tready,
	output io_links_pkg::link_out_t [io_links_pkg::nlinks-1:0] link_out
);
	import io_links_pkg::*;

	link_ctrl_t [nlinks-1:0] ctrl;
	link_stat_t [nlinks-1:0] stat;
	logic [nlinks-1:0] clear_cnt;

	link_config_regs u_regs (
		.in_clk160(in_clk160),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ctrl(ctrl),
		.stat(stat),
		.clear_cnt(clear_cnt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Lanes: serializer, delay line, deserializer
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < nlinks; i++) begin : g_lane
		line_sample_t ser_sample;
		line_sample_t dly_sample;

		link_serializer u_ser (
			.in_clk160(in_clk160),
			.rst_n(rst_n),
			.link_in(link_in[i]),
			.in_tready(in_tready[i]),
			.tristate(ctrl[i].tristate),
			.sample(ser_sample)
		);

		link_delay_line u_dly (
			.in_clk160(in_clk160),
			.rst_n(rst_n),
			.taps(ctrl[i].taps),
			.sample_in(ser_sample),
			.sample_out(dly_sample),
			.delay_ready(stat[i].delay_ready),
			.taps_out(stat[i].taps_out)
		);

		link_deserializer u_des (
			.in_clk160(in_clk160),
			.rst_n(rst_n),
			.sample(dly_sample),
			.slip(ctrl[i].slip),
			.bypass(ctrl[i].bypass),
			.link_in(link_in[i]),
			.clear_cnt(clear_cnt[i]),
			.link_out(link_out[i]),
			.err_cnt(stat[i].err_cnt)
		);
	end

endmodule

//--- testbench/tb_io_links.sv
`timescale 1ns/1ps

module tb_io_links;
	import io_links_pkg::*;

	localparam int clk_period = 4;
	localparam int loop_len = 24;
	localparam int align_len = 16;
	// Byte slots over all tests with the lanes in lockstep
	localparam int sent_bytes = loop_len + align_len + 2 + 4 + 12;
	localparam int margin_cycles = 4000;
	localparam int err_lane = 2;

	logic in_clk160;
	logic rst_n;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	link_in_t [nlinks-1:0] link_in;
	logic [nlinks-1:0] in_tready;
	link_out_t [nlinks-1:0] link_out;

	int seed;
	byte_t exp_q [nlinks][$];
	byte_t next_byte [nlinks];
	byte_t burst [nlinks][align_len];
	tap_t tap_sel [nlinks];
	slip_t slip_sel [nlinks];
	byte_t mon_want;
	apb_data_t rd;
	apb_data_t old_err;

	io_links dut (
		.in_clk160(in_clk160),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.link_in(link_in),
		.in_tready(in_tready),
		.link_out(link_out)
	);

	always #(clk_period / 2) in_clk160 = ~in_clk160;

	////////////////////////////////////////////////////////////////////////////
	// Checking and run control
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run;
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input apb_data_t got, input apb_data_t want);
		assert (got === want) else begin
			$display("ERR time=%0t %s expected=%h actual=%h", $time, name, want, got);
			abort_run();
		end
	endtask

	function automatic int pending();
		int n;
		n = 0;
		for (int l = 0; l < nlinks; l++) begin
			n += exp_q[l].size();
		end
		return n;
	endfunction

	// Timeout scaled by the number of byte slots
	initial begin
		#((sent_bytes * 16 + margin_cycles) * clk_period);
		$display("Timeout: the run did not finish within the time limit");
		abort_run();
	end

	// One expected queue per lane
	always @(posedge in_clk160) begin
		if (rst_n) begin
			for (int l = 0; l < nlinks; l++) begin
				if (link_out[l].tvalid) begin
					if (exp_q[l].size() == 0) begin
						$display("Unexpected byte %h on link_out[%0d] at time %0t",
							link_out[l].tdata, l, $time);
						abort_run();
					end else begin
						mon_want = exp_q[l].pop_front();
						check_value($sformatf("link_out[%0d].tdata", l),
							32'(link_out[l].tdata), 32'(mon_want));
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// APB access
	////////////////////////////////////////////////////////////////////////////

	function automatic apb_addr_t word_addr(input int word);
		return 8'(word * 4);
	endfunction

	function automatic apb_addr_t lane_addr(input int lane, input int sub);
		return word_addr(lane * words_per_link + sub);
	endfunction

	function automatic apb_data_t ctrl_word(input logic byp, input logic tri_en,
		input tap_t taps, input slip_t slip, input logic clr);
		return {13'd0, slip, 3'd0, taps, 5'd0, clr, tri_en, byp};
	endfunction

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic want_err);
		@(negedge in_clk160);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge in_clk160);
		penable = 1'b1;
		@(posedge in_clk160);
		check_value("pready", 32'(pready), 32'd1);
		check_value("pslverr", 32'(pslverr), 32'(want_err));
		@(negedge in_clk160);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic want_err);
		@(negedge in_clk160);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge in_clk160);
		penable = 1'b1;
		@(posedge in_clk160);
		check_value("pready", 32'(pready), 32'd1);
		check_value("pslverr", 32'(pslverr), 32'(want_err));
		data = prdata;
		@(negedge in_clk160);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic set_ctrl(input int lane, input logic byp, input logic tri_en,
		input tap_t taps, input slip_t slip, input logic clr);
		apb_write(lane_addr(lane, reg_ctrl), ctrl_word(byp, tri_en, taps, slip, clr), 1'b0);
	endtask

	task automatic wait_ready(input int lane);
		apb_data_t st;
		st = '0;
		while (st[0] != 1'b1) begin
			apb_read(lane_addr(lane, reg_status), st, 1'b0);
		end
	endtask

	task automatic wait_errors(input int lane, input apb_data_t want);
		apb_data_t cnt;
		int polls;
		polls = 0;
		apb_read(lane_addr(lane, reg_errors), cnt, 1'b0);
		while (cnt != want && polls < 64) begin
			apb_read(lane_addr(lane, reg_errors), cnt, 1'b0);
			polls++;
		end
		check_value("errors word", cnt, want);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Lane stimulus
	////////////////////////////////////////////////////////////////////////////

	// tvalid is raised only in a cycle that in_tready accepts
	task automatic send_lanes(input logic [nlinks-1:0] mask);
		@(negedge in_clk160);
		for (int l = 0; l < nlinks; l++) begin
			if (mask[l]) begin
				link_in[l].tvalid = 1'b0;
			end
		end
		while ((in_tready & mask) != mask) begin
			@(negedge in_clk160);
		end
		for (int l = 0; l < nlinks; l++) begin
			if (mask[l]) begin
				link_in[l].tdata = next_byte[l];
				link_in[l].tvalid = 1'b1;
			end
		end
	endtask

	task automatic release_lanes(input logic [nlinks-1:0] mask);
		@(negedge in_clk160);
		for (int l = 0; l < nlinks; l++) begin
			if (mask[l]) begin
				link_in[l].tvalid = 1'b0;
			end
		end
	endtask

	// Wait for the scoreboard to empty, then watch for stray bytes
	task automatic drain;
		int cycles;
		cycles = 0;
		while (pending() > 0 && cycles < 512) begin
			@(posedge in_clk160);
			cycles++;
		end
		repeat (2 * flush_cycles) @(posedge in_clk160);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h35eb_cd60;
		in_clk160 = 1'b0;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		link_in = '0;
		repeat (8) @(posedge in_clk160);
		@(negedge in_clk160);
		check_value("in_tready", 32'(in_tready), 32'd0);
		check_value("pslverr", 32'(pslverr), 32'd0);
		for (int l = 0; l < nlinks; l++) begin
			check_value("link_out.tvalid", 32'(link_out[l].tvalid), 32'd0);
		end
		rst_n = 1'b1;

		// Register map, readback and error responses
		for (int l = 0; l < nlinks; l++) begin
			apb_read(lane_addr(l, reg_status), rd, 1'b0);
			check_value("status after reset", rd, 32'h0000_0001);
		end
		apb_write(lane_addr(1, reg_ctrl), 32'hF0E5_F5FB, 1'b0);
		apb_read(lane_addr(1, reg_ctrl), rd, 1'b0);
		check_value("lane 1 ctrl", rd, 32'h0005_1503);
		apb_read(lane_addr(1, reg_status), rd, 1'b0);
		check_value("lane 1 status after tap change", rd, 32'h0000_1500);
		repeat (flush_cycles) @(posedge in_clk160);
		apb_read(lane_addr(1, reg_status), rd, 1'b0);
		check_value("lane 1 status after flush", rd, 32'h0000_1501);
		apb_write(lane_addr(0, 3), 32'hFFFF_FFFF, 1'b1);
		apb_write(word_addr(reg_global + 1), 32'hFFFF_FFFF, 1'b1);
		// Out of range words that share low index bits with lane ctrl words
		apb_write(lane_addr(nlinks + 1, reg_ctrl), 32'hFFFF_FFFF, 1'b1);
		apb_write(word_addr(2 * reg_global), 32'hFFFF_FFFF, 1'b1);
		apb_write(8'hFC, 32'hFFFF_FFFF, 1'b1);
		apb_read(lane_addr(1, 3), rd, 1'b1);
		apb_read(lane_addr(1, reg_ctrl), rd, 1'b0);
		check_value("lane 1 ctrl after bad writes", rd, 32'h0005_1503);
		apb_read(lane_addr(0, reg_ctrl), rd, 1'b0);
		check_value("lane 0 ctrl after bad writes", rd, 32'h0000_0000);
		apb_read(word_addr(reg_global), rd, 1'b0);
		check_value("global word", rd, 32'h0000_0000);
		set_ctrl(1, 1'b0, 1'b0, 5'd0, 3'd0, 1'b0);

		// Loopback on all lanes with random taps
		for (int l = 0; l < nlinks; l++) begin
			tap_sel[l] = 5'($random(seed));
			slip_sel[l] = 3'd0;
			set_ctrl(l, 1'b0, 1'b0, tap_sel[l], slip_sel[l], 1'b0);
		end
		for (int l = 0; l < nlinks; l++) begin
			wait_ready(l);
		end
		repeat (loop_len) begin
			for (int l = 0; l < nlinks; l++) begin
				next_byte[l] = 8'($random(seed));
				exp_q[l].push_back(next_byte[l]);
			end
			send_lanes('1);
		end
		release_lanes('1);
		drain();

		// Each output byte is the stream shifted by slip bits
		for (int l = 0; l < nlinks; l++) begin
			slip_sel[l] = 3'(2 * l + 1);
			set_ctrl(l, 1'b0, 1'b0, tap_sel[l], slip_sel[l], 1'b0);
			for (int k = 0; k < align_len; k++) begin
				burst[l][k] = 8'($random(seed));
			end
			for (int k = 1; k < align_len; k++) begin
				exp_q[l].push_back(8'({burst[l][k - 1], burst[l][k]} >> (8 - int'(slip_sel[l]))));
			end
		end
		for (int k = 0; k < align_len; k++) begin
			for (int l = 0; l < nlinks; l++) begin
				next_byte[l] = burst[l][k];
			end
			send_lanes('1);
		end
		release_lanes('1);
		drain();

		// Isolated byte gives two partial windows
		apb_read(lane_addr(err_lane, reg_errors), old_err, 1'b0);
		next_byte[err_lane] = 8'($random(seed));
		send_lanes(4'b0100);
		release_lanes(4'b0100);
		wait_errors(err_lane, old_err + 32'd2);
		repeat (16) @(posedge in_clk160);
		apb_read(lane_addr(err_lane, reg_errors), rd, 1'b0);
		check_value("errors word after settle", rd, old_err + 32'd2);
		set_ctrl(err_lane, 1'b0, 1'b0, tap_sel[err_lane], slip_sel[err_lane], 1'b1);
		apb_read(lane_addr(err_lane, reg_errors), rd, 1'b0);
		check_value("errors word after lane clear", rd, 32'd0);
		next_byte[err_lane] = 8'($random(seed));
		send_lanes(4'b0100);
		release_lanes(4'b0100);
		wait_errors(err_lane, 32'd2);
		apb_write(word_addr(reg_global), 32'h0000_0001, 1'b0);
		for (int l = 0; l < nlinks; l++) begin
			apb_read(lane_addr(l, reg_errors), rd, 1'b0);
			check_value("errors word after global clear", rd, 32'd0);
		end

		// Tristate lane accepts bytes but never drives the line
		set_ctrl(0, 1'b0, 1'b1, tap_sel[0], 3'd0, 1'b0);
		repeat (4) begin
			next_byte[0] = 8'($random(seed));
			send_lanes(4'b0001);
		end
		release_lanes(4'b0001);
		repeat (2 * flush_cycles) @(posedge in_clk160);
		apb_read(lane_addr(0, reg_errors), rd, 1'b0);
		check_value("tristate lane errors word", rd, 32'd0);
		set_ctrl(0, 1'b0, 1'b0, tap_sel[0], 3'd0, 1'b0);

		// Bypass ignores the line and its taps
		set_ctrl(3, 1'b1, 1'b0, 5'd9, 3'd0, 1'b0);
		repeat (12) begin
			next_byte[3] = 8'($random(seed));
			exp_q[3].push_back(next_byte[3]);
			send_lanes(4'b1000);
		end
		release_lanes(4'b1000);
		drain();

		if (pending() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("%0d expected bytes never came out of the links", pending());
			abort_run();
		end
	end

endmodule

//--- io_links.f
logic/io_links_pkg.sv
logic/link_config_regs.sv
logic/link_serializer.sv
logic/link_delay_line.sv
logic/link_deserializer.sv
logic/io_links.sv
testbench/tb_io_links.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
TOP ?= tb_io_links
FILELIST ?= io_links.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
